// File: flist.f
rtl/vec_cfg_pkg.sv
rtl/vec_isa_pkg.sv
rtl/vec_dispatcher.sv
rtl/vec_sequencer.sv
rtl/vec_vrf.sv
rtl/vec_lane.sv
rtl/vec_core.sv
sim/vec_core_sva.sv
sim/vec_core_tb.sv

// File: rtl/vec_cfg_pkg.sv
package vec_cfg_pkg;

  //////////////////////////////
  // Machine sizing
  //////////////////////////////

  localparam int unsigned NR_LANES       = 4;
  localparam int unsigned ELEN           = 32;
  localparam int unsigned NR_VREGS       = 8;
  localparam int unsigned ELEMS_PER_LANE = 8;
  localparam int unsigned MAX_VL         = NR_LANES * ELEMS_PER_LANE;

  // Derived index widths
  localparam int unsigned LANE_IDX_W = $clog2(NR_LANES);
  localparam int unsigned ROW_W      = $clog2(ELEMS_PER_LANE);
  localparam int unsigned VREG_W     = $clog2(NR_VREGS);
  localparam int unsigned VL_W       = $clog2(MAX_VL + 1);

  typedef logic [ELEN-1:0]       elem_t;
  typedef logic [VREG_W-1:0]     vreg_idx_t;
  typedef logic [VL_W-1:0]       vl_t;
  typedef logic [ROW_W-1:0]      row_t;
  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

  // Location of one element inside a lane's register slice
  typedef struct packed {
    vreg_idx_t vreg;
    row_t      row;
  } vrf_addr_t;

endpackage

// File: rtl/vec_core.sv
`timescale 1ns/10ps

module vec_core (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  vec_isa_pkg::acc_req_t  acc_req_i,
  output logic                   acc_req_ready_o,
  output vec_isa_pkg::acc_resp_t acc_resp_o
);
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;

  //////////////////////////////
  // Dispatcher
  //////////////////////////////

  vec_req_t vec_req;
  logic     vec_req_valid;
  logic     vec_req_ready;

  vec_dispatcher i_dispatcher (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .acc_req_i       (acc_req_i),
    .acc_req_ready_o (acc_req_ready_o),
    .vec_req_o       (vec_req),
    .vec_req_valid_o (vec_req_valid),
    .vec_req_ready_i (vec_req_ready)
  );

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  pe_req_t                    pe_req;
  logic                       pe_req_valid;
  logic  [NR_LANES-1:0]       lane_done;
  elem_t [NR_LANES-1:0]       ext_data;
  logic  [NR_LANES-1:0]       ext_valid;

  vec_sequencer i_sequencer (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .vec_req_i       (vec_req),
    .vec_req_valid_i (vec_req_valid),
    .vec_req_ready_o (vec_req_ready),
    .pe_req_o        (pe_req),
    .pe_req_valid_o  (pe_req_valid),
    .lane_done_i     (lane_done),
    .ext_data_i      (ext_data),
    .ext_valid_i     (ext_valid),
    .acc_resp_o      (acc_resp_o)
  );

  //////////////////////////////
  // Lanes
  //////////////////////////////

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (lane_idx_t'(l))
    ) i_lane (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .pe_req_i       (pe_req),
      .pe_req_valid_i (pe_req_valid),
      .lane_done_o    (lane_done[l]),
      .ext_data_o     (ext_data[l]),
      .ext_valid_o    (ext_valid[l])
    );
  end

endmodule

// File: rtl/vec_dispatcher.sv
`timescale 1ns/10ps

module vec_dispatcher (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  vec_isa_pkg::acc_req_t acc_req_i,
  output logic                  acc_req_ready_o,
  output vec_isa_pkg::vec_req_t vec_req_o,
  output logic                  vec_req_valid_o,
  input  logic                  vec_req_ready_i
);
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;

  logic     full_q;
  vec_req_t req_q;
  vec_req_t decoded;
  logic     accept;

  // Core sees back-pressure while the entry is occupied
  assign acc_req_ready_o = ~full_q;
  assign accept          = acc_req_i.valid & ~full_q;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin
    decoded.op        = acc_req_i.op;
    decoded.vd        = acc_req_i.vd;
    decoded.vs1       = acc_req_i.vs1;
    decoded.vs2       = acc_req_i.vs2;
    decoded.scalar    = acc_req_i.scalar;
    decoded.is_ext    = (acc_req_i.op == OP_VEXT_XV);
    decoded.writes_vd = (acc_req_i.op != OP_VEXT_XV);
    // Oversized lengths saturate at the register size
    if (acc_req_i.vl > vl_t'(MAX_VL)) begin
      decoded.vl = vl_t'(MAX_VL);
    end else begin
      decoded.vl = acc_req_i.vl;
    end
  end

  //////////////////////////////
  // One-entry buffer
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
    end else if (full_q && vec_req_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= decoded;
    end
  end

  assign vec_req_o       = req_q;
  assign vec_req_valid_o = full_q;

endmodule

// File: rtl/vec_isa_pkg.sv
package vec_isa_pkg;

  //////////////////////////////
  // Operation encoding
  //////////////////////////////

  typedef enum logic [2:0] {
    OP_VADD_VV = 3'd0,
    OP_VSUB_VV = 3'd1,
    OP_VAND_VV = 3'd2,
    OP_VXOR_VV = 3'd3,
    OP_VADD_VX = 3'd4,
    OP_VMV_VX  = 3'd5,
    OP_VEXT_XV = 3'd6
  } vec_op_e;

  //////////////////////////////
  // Core interface
  //////////////////////////////

  typedef struct packed {
    logic                   valid;
    vec_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    vec_cfg_pkg::elem_t     scalar;
    vec_cfg_pkg::vl_t       vl;
  } acc_req_t;

  typedef struct packed {
    logic               valid;
    vec_cfg_pkg::elem_t data;
  } acc_resp_t;

  // Decoded instruction, dispatcher to sequencer
  typedef struct packed {
    vec_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    vec_cfg_pkg::elem_t     scalar;
    vec_cfg_pkg::vl_t       vl;
    logic                   writes_vd;
    logic                   is_ext;
  } vec_req_t;

  // Broadcast to all lanes
  typedef struct packed {
    vec_op_e                op;
    vec_cfg_pkg::vreg_idx_t vd;
    vec_cfg_pkg::vreg_idx_t vs1;
    vec_cfg_pkg::vreg_idx_t vs2;
    vec_cfg_pkg::elem_t     scalar;
    vec_cfg_pkg::vl_t       vl;
  } pe_req_t;

endpackage

// File: rtl/vec_lane.sv
`timescale 1ns/10ps

module vec_lane #(
  parameter vec_cfg_pkg::lane_idx_t LANE_ID = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  vec_isa_pkg::pe_req_t pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 lane_done_o,
  output vec_cfg_pkg::elem_t   ext_data_o,
  output logic                 ext_valid_o
);
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;

  // Row counter must reach ELEMS_PER_LANE itself
  localparam int unsigned CNT_W = $clog2(ELEMS_PER_LANE + 1);
  typedef logic [CNT_W-1:0] cnt_t;

  pe_req_t     req_q;
  logic        busy_q;
  cnt_t        row_q;
  cnt_t        nr_rows;
  logic        is_ext;
  logic        ext_hit;
  row_t        ext_row;
  int unsigned elem_idx;
  logic        row_active;
  logic        wr_en;
  vrf_addr_t   rd_a_addr;
  vrf_addr_t   rd_b_addr;
  vrf_addr_t   wr_addr;
  elem_t       opa;
  elem_t       opb;
  elem_t       result;

  assign is_ext   = (req_q.op == OP_VEXT_XV);
  assign nr_rows  = cnt_t'((req_q.vl + NR_LANES - 1) / NR_LANES);
  assign ext_row  = req_q.scalar[LANE_IDX_W +: ROW_W];
  assign ext_hit  = (req_q.scalar[LANE_IDX_W-1:0] == LANE_ID);
  assign elem_idx = row_q * NR_LANES + LANE_ID;

  assign row_active  = busy_q & ~is_ext & (row_q < nr_rows);
  // Tail elements keep their old value
  assign wr_en       = row_active & (elem_idx < req_q.vl);
  assign lane_done_o = busy_q & (is_ext | (row_q == nr_rows));
  assign ext_valid_o = busy_q & is_ext & ext_hit;
  assign ext_data_o  = opb;

  //////////////////////////////
  // Row stepping
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      row_q  <= '0;
    end else if (pe_req_valid_i) begin
      busy_q <= 1'b1;
      row_q  <= '0;
    end else if (lane_done_o) begin
      busy_q <= 1'b0;
    end else if (row_active) begin
      row_q <= row_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pe_req_valid_i) begin
      req_q <= pe_req_i;
    end
  end

  //////////////////////////////
  // Operands and ALU
  //////////////////////////////

  assign rd_a_addr = '{vreg: req_q.vs1, row: row_t'(row_q)};
  assign rd_b_addr = '{vreg: req_q.vs2, row: is_ext ? ext_row : row_t'(row_q)};
  assign wr_addr   = '{vreg: req_q.vd, row: row_t'(row_q)};

  always_comb begin
    case (req_q.op)
      OP_VADD_VV: result = opb + opa;
      OP_VSUB_VV: result = opb - opa;
      OP_VAND_VV: result = opb & opa;
      OP_VXOR_VV: result = opb ^ opa;
      OP_VADD_VX: result = opb + req_q.scalar;
      OP_VMV_VX:  result = req_q.scalar;
      default:    result = opb;
    endcase
  end

  vec_vrf i_vrf (
    .clk_i       (clk_i),
    .rd_a_addr_i (rd_a_addr),
    .rd_a_data_o (opa),
    .rd_b_addr_i (rd_b_addr),
    .rd_b_data_o (opb),
    .wr_en_i     (wr_en),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (result)
  );

endmodule

// File: rtl/vec_sequencer.sv
`timescale 1ns/10ps

module vec_sequencer (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  vec_isa_pkg::vec_req_t                           vec_req_i,
  input  logic                                            vec_req_valid_i,
  output logic                                            vec_req_ready_o,
  output vec_isa_pkg::pe_req_t                            pe_req_o,
  output logic                                            pe_req_valid_o,
  input  logic               [vec_cfg_pkg::NR_LANES-1:0] lane_done_i,
  input  vec_cfg_pkg::elem_t [vec_cfg_pkg::NR_LANES-1:0] ext_data_i,
  input  logic               [vec_cfg_pkg::NR_LANES-1:0] ext_valid_i,
  output vec_isa_pkg::acc_resp_t                          acc_resp_o
);
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_ISSUE = 2'd1,
    SEQ_WAIT  = 2'd2
  } seq_state_e;

  seq_state_e          state_q;
  vec_req_t            req_q;
  logic [NR_LANES-1:0] pending_q;
  logic [NR_LANES-1:0] pending_next;
  logic                all_done;
  elem_t               ext_q;
  logic                resp_valid_q;

  assign vec_req_ready_o = (state_q == SEQ_IDLE);
  assign pe_req_valid_o  = (state_q == SEQ_ISSUE);

  assign pending_next = pending_q & ~lane_done_i;
  assign all_done     = (pending_next == '0);

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q      <= SEQ_IDLE;
      pending_q    <= '0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          if (vec_req_valid_i) begin
            state_q <= SEQ_ISSUE;
          end
        end
        SEQ_ISSUE: begin
          // Every lane owes one done pulse
          pending_q <= '1;
          state_q   <= SEQ_WAIT;
        end
        SEQ_WAIT: begin
          pending_q <= pending_next;
          if (all_done) begin
            resp_valid_q <= req_q.is_ext;
            state_q      <= SEQ_IDLE;
          end
        end
        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (vec_req_valid_i && vec_req_ready_o) begin
      req_q <= vec_req_i;
    end
  end

  // Only the addressed lane flags an extract
  always_ff @(posedge clk_i) begin
    for (int l = 0; l < NR_LANES; l++) begin
      if (ext_valid_i[l]) begin
        ext_q <= ext_data_i[l];
      end
    end
  end

  always_comb begin
    pe_req_o.op     = req_q.op;
    pe_req_o.vd     = req_q.vd;
    pe_req_o.vs1    = req_q.vs1;
    pe_req_o.vs2    = req_q.vs2;
    pe_req_o.scalar = req_q.scalar;
    pe_req_o.vl     = req_q.vl;
  end

  always_comb begin
    acc_resp_o.valid = resp_valid_q;
    acc_resp_o.data  = ext_q;
  end

endmodule

// File: rtl/vec_vrf.sv
`timescale 1ns/10ps

module vec_vrf (
  input  logic                   clk_i,
  input  vec_cfg_pkg::vrf_addr_t rd_a_addr_i,
  output vec_cfg_pkg::elem_t     rd_a_data_o,
  input  vec_cfg_pkg::vrf_addr_t rd_b_addr_i,
  output vec_cfg_pkg::elem_t     rd_b_data_o,
  input  logic                   wr_en_i,
  input  vec_cfg_pkg::vrf_addr_t wr_addr_i,
  input  vec_cfg_pkg::elem_t     wr_data_i
);
  import vec_cfg_pkg::*;

  localparam int unsigned DEPTH = NR_VREGS * ELEMS_PER_LANE;

  // Register-major layout, rows of one register are adjacent
  elem_t mem_q [DEPTH];

  assign rd_a_data_o = mem_q[rd_a_addr_i];
  assign rd_b_data_o = mem_q[rd_b_addr_i];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

endmodule

// File: sim/vec_core_sva.sv
`timescale 1ns/10ps

module vec_core_sva (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input vec_isa_pkg::acc_req_t  acc_req_i,
  input logic                   acc_req_ready_o,
  input vec_isa_pkg::acc_resp_t acc_resp_o
);

  // Response stays quiet once reset has been seen for a cycle
  assert property (@(posedge clk_i) (!rst_n_i [*2]) |-> !acc_resp_o.valid)
    else $error("response valid while in reset");

  // One pulse per extract, never two in a row
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_o.valid |=> !acc_resp_o.valid)
    else $error("response valid on two consecutive cycles");

  // Stalled request must not change
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (acc_req_i.valid && !acc_req_ready_o) |=> $stable(acc_req_i))
    else $error("request changed while stalled");

endmodule

// File: sim/vec_core_tb.sv
`timescale 1ns/10ps

module vec_core_tb;
  import vec_cfg_pkg::*;
  import vec_isa_pkg::*;

  localparam int unsigned NR_SWEEPS = 8;
  localparam int unsigned NR_INSTR  = (NR_VREGS + 2 * MAX_VL) + (30 + NR_VREGS * MAX_VL)
                                    + 2 * NR_SWEEPS * (1 + MAX_VL) + 40;
  localparam int unsigned TIMEOUT   = NR_INSTR * (ELEMS_PER_LANE + 8) + 100;

  logic      clk_i;
  logic      rst_n_i;
  acc_req_t  acc_req_i;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;

  elem_t       ref_vrf [NR_VREGS][MAX_VL];
  elem_t       exp_q [$];
  logic [31:0] lfsr = 32'he8e2f659;
  int unsigned err_cnt = 0;
  int unsigned check_cnt = 0;
  int unsigned stall_cnt = 0;
  int unsigned accept_cnt = 0;
  int unsigned test_errs = 0;
  int unsigned fixed_vl [4] = '{0, 1, 5, 32};

  vec_core DUT (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .acc_req_i       (acc_req_i),
    .acc_req_ready_o (acc_req_ready_o),
    .acc_resp_o      (acc_resp_o)
  );

  bind vec_core vec_core_sva i_sva (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .acc_req_i       (acc_req_i),
    .acc_req_ready_o (acc_req_ready_o),
    .acc_resp_o      (acc_resp_o)
  );

  always #2 clk_i = ~clk_i;

  ////////////////////////////////
  // Helpers
  ////////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
        lfsr = lfsr ^ 32'hB4BCD35C;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  function automatic acc_req_t build_req(input vec_op_e op, input vreg_idx_t vd,
                                         input vreg_idx_t vs1, input vreg_idx_t vs2,
                                         input elem_t scalar, input vl_t vl);
    acc_req_t req;
    req = '{valid: 1'b0, op: op, vd: vd, vs1: vs1, vs2: vs2, scalar: scalar, vl: vl};
    return req;
  endfunction

  // Shadow model, element i updated only below vl
  function automatic void ref_exec(input acc_req_t req);
    elem_t a;
    elem_t b;
    if (req.op == OP_VEXT_XV) begin
      exp_q.push_back(ref_vrf[req.vs2][req.scalar % MAX_VL]);
    end else begin
      for (int i = 0; i < MAX_VL; i++) begin
        a = ref_vrf[req.vs1][i];
        b = ref_vrf[req.vs2][i];
        if (i < req.vl) begin
          case (req.op)
            OP_VADD_VV: ref_vrf[req.vd][i] = b + a;
            OP_VSUB_VV: ref_vrf[req.vd][i] = b - a;
            OP_VAND_VV: ref_vrf[req.vd][i] = b & a;
            OP_VXOR_VV: ref_vrf[req.vd][i] = b ^ a;
            OP_VADD_VX: ref_vrf[req.vd][i] = b + req.scalar;
            default:    ref_vrf[req.vd][i] = req.scalar;
          endcase
        end
      end
    end
  endfunction

  task automatic check_value(input logic [31:0] exp, input logic [31:0] act,
                             input string what);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, act);
    end
  endtask

  // Holds valid until the core takes the request
  task automatic send_req(input acc_req_t req);
    req.valid = 1'b1;
    acc_req_i = req;
    while (!acc_req_ready_o) begin
      stall_cnt++;
      @(negedge clk_i);
    end
    ref_exec(req);
    @(negedge clk_i);
    acc_req_i.valid = 1'b0;
  endtask

  task automatic extract_all(input vreg_idx_t vs2);
    for (int i = 0; i < MAX_VL; i++) begin
      send_req(build_req(OP_VEXT_XV, '0, '0, vs2, elem_t'(i), '0));
    end
  endtask

  task automatic end_test(input string name);
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    $display("%s finished with %0d errors", name, err_cnt - test_errs);
    test_errs = err_cnt;
  endtask

  ////////////////////////////////
  // Response compare
  ////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_n_i && acc_resp_o.valid) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("unexpected response at %0t with data %h", $time, acc_resp_o.data);
      end else begin
        check_value(exp_q.pop_front(), acc_resp_o.data, "extract data");
      end
    end
  end

  // Requests taken by the DUT, one per valid and ready edge
  always @(posedge clk_i) begin
    if (rst_n_i && acc_req_i.valid && acc_req_ready_o) begin
      accept_cnt++;
    end
  end

  initial begin
    repeat (TIMEOUT) @(posedge clk_i);
    $display("timeout, %0d extract responses are still missing", exp_q.size());
    $display("test failed");
    $finish;
  end

  ////////////////////////////////
  // Stimulus
  ////////////////////////////////

  initial begin
    int unsigned accepts;
    int unsigned stalls;
    vl_t         vl;
    vreg_idx_t   vd;
    vec_op_e     op;
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    acc_req_i = '0;
    repeat (16) @(negedge clk_i);
    rst_n_i = 1'b1;

    check_value(32'(acc_req_ready_o), 32'd1, "ready after reset");
    repeat (20) @(negedge clk_i);
    end_test("idle after reset");

    for (int r = 0; r < NR_VREGS; r++) begin
      send_req(build_req(OP_VMV_VX, vreg_idx_t'(r), '0, '0, rand_bits(32), vl_t'(MAX_VL)));
    end
    for (int i = 0; i < MAX_VL; i++) begin
      send_req(build_req(OP_VEXT_XV, '0, '0, vreg_idx_t'(i), elem_t'(i), '0));
      send_req(build_req(OP_VEXT_XV, '0, '0, vreg_idx_t'(i + 5), elem_t'(i), '0));
    end
    end_test("splat and extract");

    for (int k = 0; k < 30; k++) begin
      send_req(build_req(vec_op_e'(rand_bits(2)), vreg_idx_t'(rand_bits(3)),
                         vreg_idx_t'(rand_bits(3)), vreg_idx_t'(rand_bits(3)),
                         '0, vl_t'(MAX_VL)));
    end
    for (int r = 0; r < NR_VREGS; r++) begin
      extract_all(vreg_idx_t'(r));
    end
    end_test("vector-vector arithmetic");

    for (int k = 0; k < NR_SWEEPS; k++) begin
      vl = (k < 4) ? vl_t'(fixed_vl[k]) : vl_t'(rand_bits(6) % (MAX_VL + 1));
      vd = vreg_idx_t'(rand_bits(3));
      send_req(build_req(vec_op_e'(rand_bits(2)), vd, vreg_idx_t'(rand_bits(3)),
                         vreg_idx_t'(rand_bits(3)), '0, vl));
      extract_all(vd);
    end
    end_test("partial vl");

    for (int k = 0; k < NR_SWEEPS; k++) begin
      vl = vl_t'(rand_bits(6) % (MAX_VL + 1));
      vd = vreg_idx_t'(rand_bits(3));
      send_req(build_req(OP_VADD_VX, vd, '0, vreg_idx_t'(rand_bits(3)), rand_bits(32), vl));
      extract_all(vd);
    end
    end_test("vector-scalar");

    accepts = accept_cnt;
    stalls  = stall_cnt;
    for (int k = 0; k < 40; k++) begin
      op = vec_op_e'(rand_bits(3) % 7);
      vl = vl_t'(rand_bits(6) % (MAX_VL + 1));
      if (op == OP_VEXT_XV) begin
        send_req(build_req(op, '0, '0, vreg_idx_t'(rand_bits(3)), rand_bits(5), vl));
      end else begin
        send_req(build_req(op, vreg_idx_t'(rand_bits(3)), vreg_idx_t'(rand_bits(3)),
                           vreg_idx_t'(rand_bits(3)), rand_bits(32), vl));
      end
    end
    end_test("back-to-back issue");
    check_value(accept_cnt - accepts, 32'd40, "accepted requests");
    check_value(32'(stall_cnt > stalls), 32'd1, "ready dropped with full buffer");

    $display("%0d checks, %0d errors, %0d requests", check_cnt, err_cnt, accept_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
